/* vlog.f */
+incdir+rtl
rtl/dsa_pkg.sv
rtl/dsa_arith_unit.sv
rtl/dsa_result_regs.sv
rtl/dsa_sequencer.sv
rtl/dsa_ctrl.sv
test/tb_clock_gen.sv
test/dsa_ctrl_properties.sv
test/dsa_ctrl_tb.sv

/* test/dsa_ctrl_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dsa_ctrl_tb import dsa_pkg::*; ();

    localparam int          CLK_PERIOD     = 100;
    localparam int          DRIVE_DLY      = 10;
    localparam int          SEED           = 2437;
    localparam int          CMD_BUDGET     = 20;
    localparam int          CYCLES_PER_CMD = 200;
    localparam int unsigned TIMEOUT_CYCLES = CMD_BUDGET * CYCLES_PER_CMD;

    logic        clk;
    logic        reset_n;
    logic        cmd_valid;
    logic        cmd_ready;
    cmd_t        cmd;
    logic        res_valid;
    logic        res_ready;
    result_t     res;
    int unsigned cycle_cnt;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(10)) u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    dsa_ctrl DUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd_valid_i (cmd_valid),
        .cmd_ready_o (cmd_ready),
        .cmd_i       (cmd),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready),
        .res_o       (res)
    );

    //------------------------------------------------------------------------
    // timeout
    //------------------------------------------------------------------------
    initial cycle_cnt = 0;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_cnt);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    // a failed handshake assertion ends the run at the next edge
    always @(posedge clk) begin
        if (DUT.u_properties.fail_cnt != 0) begin
            $display("a handshake assertion failed, see the error above");
            $display("Simulation FAILED");
            $fatal(1, "assertion failure");
        end
    end

    //------------------------------------------------------------------------
    // helpers
    //------------------------------------------------------------------------
    task automatic tick();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic cmd_t make_cmd(input dsa_cmd_e kind, input word_t pk, input word_t msg,
                                      input word_t r, input word_t mask);
        cmd_t c;
        c.cmd     = kind;
        c.privkey = pk;
        c.msg     = msg;
        c.r       = r;
        c.mask    = mask;
        return c;
    endfunction

    function automatic word_t rand_key();
        return word_t'(1 + ($urandom % (int'(Q_MOD) - 1)));
    endfunction

    // pubkey = privkey * 7 mod q
    function automatic word_t expect_pubkey(input word_t pk);
        longint unsigned p;
        p = pk;
        return word_t'((p * 7) % 65521);
    endfunction

    // s = privkey * r + h mod q
    function automatic word_t expect_sign(input word_t pk, input word_t r, input word_t msg);
        longint unsigned p;
        longint unsigned rr;
        longint unsigned h;
        p  = pk;
        rr = r;
        h  = msg;
        return word_t'((p * rr + h) % 65521);
    endfunction

    task automatic send_cmd(input cmd_t c);
        logic accepted;
        accepted  = 1'b0;
        cmd       = c;
        cmd_valid = 1'b1;
        while (!accepted) begin
            accepted = cmd_ready;
            tick();
        end
        cmd_valid = 1'b0;
    endtask

    task automatic take_result(output result_t r);
        while (!res_valid) tick();
        r         = res;
        res_ready = 1'b1;
        tick();
        res_ready = 1'b0;
    endtask

    task automatic run_cmd(input cmd_t c, output result_t r);
        send_cmd(c);
        take_result(r);
    endtask

    //------------------------------------------------------------------------
    // directed tests
    //------------------------------------------------------------------------
    task automatic test_keygen(input int n);
        word_t   keys[$];
        cmd_t    c;
        result_t r;
        keys = {16'd1, 16'd65520};
        for (int i = 0; i < n; i++) keys.push_back(rand_key());
        foreach (keys[i]) begin
            c = make_cmd(KEYGEN, keys[i], word_t'($urandom), word_t'($urandom),
                         word_t'($urandom));
            run_cmd(c, r);
            check_equal("res_o.pubkey", r.pubkey, expect_pubkey(keys[i]));
            check_equal("res_o.sign_s", r.sign_s, 0);
            check_equal("res_o.error", r.error, 0);
        end
    endtask

    task automatic test_sign(input int n);
        cmd_t    c;
        result_t r;
        for (int i = 0; i < n; i++) begin
            c = make_cmd(SIGN, rand_key(), word_t'($urandom), word_t'($urandom),
                         word_t'($urandom));
            run_cmd(c, r);
            check_equal("res_o.sign_s", r.sign_s, expect_sign(c.privkey, c.r, c.msg));
            check_equal("res_o.pubkey", r.pubkey, 0);
            check_equal("res_o.error", r.error, 0);
        end
    endtask

    // same command, several masks, one signature
    task automatic test_masking();
        word_t   masks[4];
        cmd_t    c;
        result_t r;
        word_t   first_s;
        masks = '{16'h0000, 16'h0001, word_t'($urandom), 16'hffff};
        c = make_cmd(SIGN, rand_key(), word_t'($urandom), word_t'($urandom), 16'h0000);
        foreach (masks[i]) begin
            c.mask = masks[i];
            run_cmd(c, r);
            if (i == 0) first_s = r.sign_s;
            check_equal("res_o.sign_s", r.sign_s, first_s);
            check_equal("res_o.sign_s", r.sign_s, expect_sign(c.privkey, c.r, c.msg));
        end
    endtask

    task automatic test_range_errors();
        word_t    bad_keys[4];
        dsa_cmd_e kinds[4];
        cmd_t     c;
        result_t  r;
        bad_keys = '{16'd0, Q_MOD, 16'hffff, word_t'(65521 + ($urandom % 15))};
        kinds    = '{KEYGEN, SIGN, KEYGEN, SIGN};
        foreach (bad_keys[i]) begin
            c = make_cmd(kinds[i], bad_keys[i], word_t'($urandom), word_t'($urandom),
                         word_t'($urandom));
            send_cmd(c);
            // abort shows up two cycles after acceptance
            tick();
            check_equal("res_valid_o", res_valid, 0);
            tick();
            check_equal("res_valid_o", res_valid, 1);
            take_result(r);
            check_equal("res_o.error", r.error, 1);
            check_equal("res_o.pubkey", r.pubkey, 0);
            check_equal("res_o.sign_s", r.sign_s, 0);
        end
    endtask

    task automatic test_back_pressure();
        cmd_t        c_sign;
        cmd_t        c_next;
        result_t     held;
        result_t     r;
        int unsigned hold_cycles;
        c_sign = make_cmd(SIGN, rand_key(), word_t'($urandom), word_t'($urandom),
                          word_t'($urandom));
        c_next = make_cmd(KEYGEN, rand_key(), 16'd0, 16'd0, 16'd0);
        send_cmd(c_sign);
        while (!res_valid) tick();
        held = res;
        // offer the next command while the result is stalled
        cmd         = c_next;
        cmd_valid   = 1'b1;
        hold_cycles = 3 + ($urandom % 20);
        repeat (hold_cycles) begin
            tick();
            check_equal("res_valid_o", res_valid, 1);
            check_equal("cmd_ready_o", cmd_ready, 0);
            check_equal("res_o", res, held);
        end
        take_result(r);
        check_equal("res_o.sign_s", r.sign_s, expect_sign(c_sign.privkey, c_sign.r, c_sign.msg));
        send_cmd(c_next);
        take_result(r);
        check_equal("res_o.pubkey", r.pubkey, expect_pubkey(c_next.privkey));
        check_equal("res_o.sign_s", r.sign_s, 0);
    endtask

    //------------------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------------------
    initial begin
        cmd_valid = 1'b0;
        cmd       = '0;
        res_ready = 1'b0;
        void'($urandom(SEED));
        @(posedge reset_n);
        tick();
        test_keygen(3);
        test_sign(5);
        test_masking();
        test_range_errors();
        test_back_pressure();
        tick();
        if (DUT.u_properties.fail_cnt != 0) begin
            $display("%0d assertion failures were seen", DUT.u_properties.fail_cnt);
            $display("Simulation FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* test/dsa_ctrl_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module dsa_ctrl_properties import dsa_pkg::*; (
    input wire      clk,
    input wire      reset_n,
    input logic     cmd_ready_i,
    input logic     res_valid_i,
    input logic     res_ready_i,
    input result_t  res_i
);

    int unsigned fail_cnt;

    initial fail_cnt = 0;

    //------------------------------------------------------------------------
    // result handshake
    //------------------------------------------------------------------------
    // no new command while a result waits to be taken
    a_ready_low_while_valid: assert property (
        @(posedge clk) disable iff (!reset_n) res_valid_i |-> !cmd_ready_i
    ) else begin
        fail_cnt++;
        $error("cmd_ready_o high while res_valid_o is high");
    end

    a_res_stable: assert property (
        @(posedge clk) disable iff (!reset_n)
        (res_valid_i && !res_ready_i) |=> (res_valid_i && $stable(res_i))
    ) else begin
        fail_cnt++;
        $error("res_o or res_valid_o changed under back-pressure");
    end

    // reset state
    a_idle_after_reset: assert property (
        @(posedge clk) $rose(reset_n) |-> (!res_valid_i && cmd_ready_i)
    ) else begin
        fail_cnt++;
        $error("controller not idle after reset release");
    end

endmodule

bind dsa_ctrl dsa_ctrl_properties u_properties (
    .clk         (clk),
    .reset_n     (reset_n),
    .cmd_ready_i (cmd_ready_o),
    .res_valid_i (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_i       (res_o)
);

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release reset a little after an edge, away from the sampling point
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD_NS / 10) reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/dsa_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dsa_ctrl import dsa_pkg::*; (
    input  wire      clk,
    input  wire      reset_n,
    input  logic     cmd_valid_i,
    output logic     cmd_ready_o,
    input  cmd_t     cmd_i,
    output logic     res_valid_o,
    input  logic     res_ready_i,
    output result_t  res_o
);

    logic uop_valid;
    uop_t uop;
    logic core_busy;
    rd_t  rd;
    logic finish;
    logic error;

    //------------------------------------------------------------------------
    // decode, execute, result
    //------------------------------------------------------------------------
    dsa_sequencer u_sequencer (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .cmd_ready_o (cmd_ready_o),
        .core_busy_i (core_busy),
        .res_valid_i (res_valid_o),
        .res_ready_i (res_ready_i),
        .uop_valid_o (uop_valid),
        .uop_o       (uop),
        .finish_o    (finish),
        .error_o     (error)
    );

    dsa_arith_unit u_arith_unit (
        .clk         (clk),
        .reset_n     (reset_n),
        .uop_valid_i (uop_valid),
        .uop_i       (uop),
        .busy_o      (core_busy),
        .rd_o        (rd)
    );

    dsa_result_regs u_result_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .rd_i        (rd),
        .finish_i    (finish),
        .error_i     (error),
        .res_ready_i (res_ready_i),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

endmodule

`default_nettype wire

/* rtl/dsa_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module dsa_sequencer import dsa_pkg::*; (
    input  wire   clk,
    input  wire   reset_n,
    input  logic  cmd_valid_i,
    input  cmd_t  cmd_i,
    output logic  cmd_ready_o,
    input  logic  core_busy_i,
    input  logic  res_valid_i,
    input  logic  res_ready_i,
    output logic  uop_valid_o,
    output uop_t  uop_o,
    output logic  finish_o,
    output logic  error_o
);

    seq_state_e state_q;
    prog_addr_t pc_q;
    cmd_t       cmd_q;
    instr_t     instr;
    word_t      wr_word;
    logic       key_bad;
    logic       issue;

    `include "dsa_microcode.svh"

    assign instr       = dsa_rom(pc_q);
    assign cmd_ready_o = (state_q == ST_IDLE);

    // privkey must lie in [1, Q_MOD-1]
    assign key_bad = (cmd_q.privkey == '0) || (cmd_q.privkey >= Q_MOD);
    assign issue   = (state_q == ST_RUN) && !key_bad && (instr.opcode != UOP_END);

    always_comb begin
        wr_word = '0;
        case (instr.opcode)
            UOP_WR_CORE: begin
                case (instr.reg_id)
                    ID_PRIVKEY: wr_word = cmd_q.privkey;
                    ID_MSG:     wr_word = cmd_q.msg;
                    ID_R:       wr_word = cmd_q.r;
                    ID_MASK:    wr_word = cmd_q.mask;
                    ID_GEN:     wr_word = GEN_CONST;
                    default:    wr_word = '0;
                endcase
            end
            UOP_RD_CORE: wr_word = word_t'(instr.reg_id);
            default:     wr_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cmd_valid_i && cmd_ready_o) begin
            cmd_q <= cmd_i;
        end
        if (issue) begin
            uop_o <= '{instr.opcode, instr.dst, instr.src_a, instr.src_b, wr_word};
        end
    end

    //------------------------------------------------------------------------
    // program counter FSM
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q     <= ST_IDLE;
            pc_q        <= DSA_KG_S;
            uop_valid_o <= 1'b0;
            finish_o    <= 1'b0;
            error_o     <= 1'b0;
        end else begin
            uop_valid_o <= 1'b0;
            finish_o    <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (cmd_valid_i) begin
                        state_q <= ST_RUN;
                        pc_q    <= (cmd_i.cmd == KEYGEN) ? DSA_KG_S : DSA_SGN_S;
                    end
                end
                ST_RUN: begin
                    if (key_bad) begin
                        // abort before anything reaches the core
                        state_q  <= ST_DONE;
                        finish_o <= 1'b1;
                        error_o  <= 1'b1;
                    end else if (instr.opcode == UOP_END) begin
                        state_q  <= ST_DONE;
                        finish_o <= 1'b1;
                        error_o  <= 1'b0;
                    end else begin
                        uop_valid_o <= 1'b1;
                        pc_q        <= pc_q + 5'd1;
                        if (instr.opcode == UOP_MUL) begin
                            state_q <= ST_WAIT;
                        end
                    end
                end
                // busy rises one cycle after the uop, so hold while it is in flight
                ST_WAIT: begin
                    if (!core_busy_i && !uop_valid_o) begin
                        state_q <= ST_RUN;
                    end
                end
                ST_DONE: begin
                    if (res_valid_i && res_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/dsa_result_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module dsa_result_regs import dsa_pkg::*; (
    input  wire      clk,
    input  wire      reset_n,
    input  rd_t      rd_i,
    input  logic     finish_i,
    input  logic     error_i,
    input  logic     res_ready_i,
    output logic     res_valid_o,
    output result_t  res_o
);

    word_t pubkey_q;
    word_t sign_s_q;
    logic  error_q;
    logic  valid_q;
    logic  taken;

    assign taken = valid_q && res_ready_i;

    //------------------------------------------------------------------------
    // valid flag and error bit
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
            error_q <= 1'b0;
        end else if (finish_i) begin
            valid_q <= 1'b1;
            error_q <= error_i;
        end else if (taken) begin
            valid_q <= 1'b0;
            error_q <= 1'b0;
        end
    end

    // result words, cleared once taken so unused ones read zero
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pubkey_q <= '0;
            sign_s_q <= '0;
        end else if (taken) begin
            pubkey_q <= '0;
            sign_s_q <= '0;
        end else if (rd_i.capture) begin
            case (rd_i.reg_id)
                ID_PUBKEY: pubkey_q <= rd_i.data;
                ID_SIGN_S: sign_s_q <= rd_i.data;
                default: ;
            endcase
        end
    end

    assign res_valid_o = valid_q;
    assign res_o       = '{pubkey: pubkey_q, sign_s: sign_s_q, error: error_q};

endmodule

`default_nettype wire

/* rtl/dsa_arith_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module dsa_arith_unit import dsa_pkg::*; (
    input  wire   clk,
    input  wire   reset_n,
    input  logic  uop_valid_i,
    input  uop_t  uop_i,
    output logic  busy_o,
    output rd_t   rd_o
);

    word_t                mem [2**MEM_ADDR_W];
    word_t                op_a;
    word_t                op_b;
    word_t                mul_a;
    word_t                mul_b;
    word_t                acc_q;
    word_t                acc_step;
    mem_addr_t            mul_dst;
    logic [MUL_CNT_W-1:0] cnt_q;
    logic                 mul_last;
    logic                 rd_cap_q;
    reg_id_e              rd_id_q;
    word_t                rd_data_q;

    //------------------------------------------------------------------------
    // modular helpers, inputs already below Q_MOD
    //------------------------------------------------------------------------
    function automatic word_t add_mod(input word_t a, input word_t b);
        logic [WORD_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, Q_MOD}) sum = sum - {1'b0, Q_MOD};
        return sum[WORD_W-1:0];
    endfunction

    function automatic word_t sub_mod(input word_t a, input word_t b);
        logic [WORD_W:0] diff;
        diff = {1'b0, a} - {1'b0, b};
        if (a < b) diff = diff + {1'b0, Q_MOD};
        return diff[WORD_W-1:0];
    endfunction

    // any 16-bit word is below 2*Q_MOD, one subtract is enough
    function automatic word_t reduce(input word_t w);
        return (w >= Q_MOD) ? w - Q_MOD : w;
    endfunction

    assign op_a     = mem[uop_i.src_a];
    assign op_b     = mem[uop_i.src_b];
    assign mul_last = (cnt_q == MUL_CNT_W'(WORD_W - 1));

    // msb first: acc = 2*acc + bit*a, reduced every step
    always_comb begin
        acc_step = add_mod(acc_q, acc_q);
        if (mul_b[WORD_W-1]) acc_step = add_mod(acc_step, mul_a);
    end

    always_ff @(posedge clk) begin
        if (busy_o) begin
            acc_q <= acc_step;
            mul_b <= mul_b << 1;
            if (mul_last) mem[mul_dst] <= acc_step;
        end else if (uop_valid_i) begin
            case (uop_i.opcode)
                UOP_WR_CORE: mem[uop_i.dst] <= reduce(uop_i.wdata);
                UOP_ADD:     mem[uop_i.dst] <= add_mod(op_a, op_b);
                UOP_SUB:     mem[uop_i.dst] <= sub_mod(op_a, op_b);
                UOP_MUL: begin
                    mul_a   <= op_a;
                    mul_b   <= op_b;
                    acc_q   <= '0;
                    mul_dst <= uop_i.dst;
                end
                default: ;
            endcase
        end
        rd_id_q   <= reg_id_e'(uop_i.wdata[$bits(reg_id_e)-1:0]);
        rd_data_q <= op_a;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_o   <= 1'b0;
            cnt_q    <= '0;
            rd_cap_q <= 1'b0;
        end else begin
            rd_cap_q <= uop_valid_i && (uop_i.opcode == UOP_RD_CORE);
            if (busy_o) begin
                cnt_q <= cnt_q + 1'b1;
                if (mul_last) busy_o <= 1'b0;
            end else if (uop_valid_i && (uop_i.opcode == UOP_MUL)) begin
                busy_o <= 1'b1;
                cnt_q  <= '0;
            end
        end
    end

    assign rd_o = '{capture: rd_cap_q, reg_id: rd_id_q, data: rd_data_q};

endmodule

`default_nettype wire

/* rtl/dsa_pkg.sv */
`default_nettype none

package dsa_pkg;

    //------------------------------------------------------------------------
    // widths
    //------------------------------------------------------------------------
    localparam int WORD_W      = 16;
    localparam int MEM_ADDR_W  = 3;
    localparam int PROG_ADDR_W = 5;
    localparam int MUL_CNT_W   = $clog2(WORD_W);

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
    typedef logic [PROG_ADDR_W-1:0] prog_addr_t;

    //------------------------------------------------------------------------
    // field and program constants
    //------------------------------------------------------------------------
    localparam word_t Q_MOD     = 16'd65521;
    localparam word_t GEN_CONST = 16'd7;

    // program entry points in the instruction ROM
    localparam prog_addr_t DSA_KG_S  = 5'd0;
    localparam prog_addr_t DSA_SGN_S = 5'd8;

    typedef enum logic {KEYGEN, SIGN} dsa_cmd_e;

    typedef enum logic [2:0] {
        UOP_NOP, UOP_WR_CORE, UOP_ADD, UOP_SUB, UOP_MUL, UOP_RD_CORE, UOP_END
    } uop_e;

    typedef enum logic [2:0] {
        ID_PRIVKEY, ID_MSG, ID_R, ID_MASK, ID_GEN, ID_PUBKEY, ID_SIGN_S
    } reg_id_e;

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_WAIT, ST_DONE} seq_state_e;

    //------------------------------------------------------------------------
    // bundles
    //------------------------------------------------------------------------
    typedef struct packed {
        uop_e      opcode;
        reg_id_e   reg_id;
        mem_addr_t dst;
        mem_addr_t src_a;
        mem_addr_t src_b;
    } instr_t;

    typedef struct packed {
        dsa_cmd_e cmd;
        word_t    privkey;
        word_t    msg;
        word_t    r;
        word_t    mask;
    } cmd_t;

    // for UOP_RD_CORE the low bits of wdata carry the destination reg_id
    typedef struct packed {
        uop_e      opcode;
        mem_addr_t dst;
        mem_addr_t src_a;
        mem_addr_t src_b;
        word_t     wdata;
    } uop_t;

    typedef struct packed {
        logic    capture;
        reg_id_e reg_id;
        word_t   data;
    } rd_t;

    typedef struct packed {
        word_t pubkey;
        word_t sign_s;
        logic  error;
    } result_t;

endpackage

`default_nettype wire

/* rtl/dsa_microcode.svh */
`ifndef DSA_MICROCODE_SVH
`define DSA_MICROCODE_SVH

// instruction ROM, fields are opcode, reg_id, dst, src_a, src_b
function automatic instr_t dsa_rom(input prog_addr_t addr);
    instr_t ins;
    case (addr)
        // keygen: m2 = privkey * gen
        5'd0:  ins = '{UOP_WR_CORE, ID_PRIVKEY, 3'd0, 3'd0, 3'd0};
        5'd1:  ins = '{UOP_WR_CORE, ID_GEN,     3'd1, 3'd0, 3'd0};
        5'd2:  ins = '{UOP_MUL,     ID_PRIVKEY, 3'd2, 3'd0, 3'd1};
        5'd3:  ins = '{UOP_RD_CORE, ID_PUBKEY,  3'd0, 3'd2, 3'd0};
        5'd4:  ins = '{UOP_END,     ID_PRIVKEY, 3'd0, 3'd0, 3'd0};
        // sign: m0 privkey, m1 msg, m2 r, m3 mask d
        5'd8:  ins = '{UOP_WR_CORE, ID_PRIVKEY, 3'd0, 3'd0, 3'd0};
        5'd9:  ins = '{UOP_WR_CORE, ID_MSG,     3'd1, 3'd0, 3'd0};
        5'd10: ins = '{UOP_WR_CORE, ID_R,       3'd2, 3'd0, 3'd0};
        5'd11: ins = '{UOP_WR_CORE, ID_MASK,    3'd3, 3'd0, 3'd0};
        // masked half: (privkey - d) * r + (h - d)
        5'd12: ins = '{UOP_SUB,     ID_PRIVKEY, 3'd4, 3'd0, 3'd3};
        5'd13: ins = '{UOP_MUL,     ID_PRIVKEY, 3'd4, 3'd4, 3'd2};
        5'd14: ins = '{UOP_SUB,     ID_PRIVKEY, 3'd5, 3'd1, 3'd3};
        5'd15: ins = '{UOP_ADD,     ID_PRIVKEY, 3'd4, 3'd4, 3'd5};
        // mask half: d * r + d
        5'd16: ins = '{UOP_MUL,     ID_PRIVKEY, 3'd5, 3'd3, 3'd2};
        5'd17: ins = '{UOP_ADD,     ID_PRIVKEY, 3'd5, 3'd5, 3'd3};
        5'd18: ins = '{UOP_ADD,     ID_PRIVKEY, 3'd6, 3'd4, 3'd5};
        5'd19: ins = '{UOP_RD_CORE, ID_SIGN_S,  3'd0, 3'd6, 3'd0};
        5'd20: ins = '{UOP_END,     ID_PRIVKEY, 3'd0, 3'd0, 3'd0};
        default: ins = '{UOP_END,   ID_PRIVKEY, 3'd0, 3'd0, 3'd0};
    endcase
    return ins;
endfunction

`endif
